//--- layer_cfg_pkg.sv
package layer_cfg_pkg;

    //////////////////////////////////////////////////
    // Layer sequencer state
    //////////////////////////////////////////////////

    // One-hot, one bit per sequencer state
    typedef enum logic [7:0] {
        st_idle            = 8'b0000_0001,
        st_ld_1x1_krn      = 8'b0000_0010,
        st_ld_1x1_krb      = 8'b0000_0100,
        st_cfg_awp         = 8'b0000_1000,
        st_start_awp       = 8'b0001_0000,
        st_active          = 8'b0010_0000,
        st_wait_last_write = 8'b0100_0000,
        st_send_complete   = 8'b1000_0000
    } layer_state_t;

    //////////////////////////////////////////////////
    // Operation word
    //////////////////////////////////////////////////

    // One-hot operation select from the layer config
    typedef logic [17:0] opcode_cfg_t;

    // Bit positions inside opcode_cfg_t
    localparam int unsigned op_0  = 0;
    localparam int unsigned op_1  = 1;
    localparam int unsigned op_2  = 2;
    localparam int unsigned op_3  = 3;
    localparam int unsigned op_4  = 4;
    localparam int unsigned op_5  = 5;
    localparam int unsigned op_6  = 6;
    localparam int unsigned op_7  = 7;
    localparam int unsigned op_8  = 8;
    localparam int unsigned op_9  = 9;
    localparam int unsigned op_10 = 10;
    localparam int unsigned op_11 = 11;
    // Ops 12 and 16 have no 1x1 pipeline work
    localparam int unsigned op_12 = 12;
    localparam int unsigned op_13 = 13;
    localparam int unsigned op_14 = 14;
    localparam int unsigned op_15 = 15;
    localparam int unsigned op_16 = 16;
    localparam int unsigned op_17 = 17;

    // Kernel index, zero on first kernel of a pass
    typedef logic [15:0] krnl_count_t;

endpackage

//--- pipe_timing_pkg.sv
package pipe_timing_pkg;

    //////////////////////////////////////////////////
    // Pipeline latencies
    //////////////////////////////////////////////////

    // Read latency of the conv, part, resd and prev map FIFOs
    localparam int fas_fifo_latency_default = 2;

    // Vector adder latency
    localparam int vec_add_latency_default = 3;

    //////////////////////////////////////////////////
    // Derived delays
    //////////////////////////////////////////////////

    // Residual-1 strobe
    // Waits for two FIFO reads and one pass through the adder
    localparam int resd1_delay_default =
        2 * fas_fifo_latency_default + vec_add_latency_default;

endpackage

//--- pip_delay_line.sv
module pip_delay_line #(
    parameter int depth = 2
) (
    input  logic clk_FAS,
    input  logic rst_n,
    input  logic din,
    output logic dout
);

    // Shift chain, stage 0 takes din
    logic [depth-1:0] sr;

    //////////////////////////////////////////////////
    // Shift register
    //////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            // Drop anything in flight
            sr <= '0;
        end else begin
            sr[0] <= din;
            // Remaining stages
            // loop body is skipped when depth is 1
            for (int i = 1; i < depth; i++) begin
                sr[i] <= sr[i-1];
            end
        end
    end

    // Last stage
    assign dout = sr[depth-1];

endmodule

//--- pip_issue.sv
module pip_issue (
    input  logic                       clk_FAS,
    input  logic                       rst_n,
    input  logic                       fas_rdy_n,
    input  layer_cfg_pkg::opcode_cfg_t  opcode_cfg,
    input  layer_cfg_pkg::layer_state_t state,
    input  logic                       conv_map_empty,
    input  logic                       part_map_empty,
    input  logic                       resd_map_empty,
    input  logic                       prev_map_empty,
    input  layer_cfg_pkg::krnl_count_t  krnl_count,
    input  logic                       dwc_fifo_rden,
    input  logic                       pipe_busy,
    output logic                       issue_pipe,
    output logic                       issue_pm,
    output logic                       issue_rm0,
    output logic                       issue_rm1,
    output logic                       issue_rm_conv,
    output logic                       issue_pv,
    output logic                       conv1x1_pip_start0,
    output logic                       conv1x1_pip_start1,
    output logic                       conv1x1_pip_start2,
    output logic                       outbuf_fifo_wren1,
    output logic                       outbuf_fifo_wren2
);

    import layer_cfg_pkg::*;

    // Layer may feed the pipeline
    logic state_ok;
    // Map data available
    logic conv_rdy;
    logic part_rdy;
    logic resd_rdy;
    logic prev_rdy;
    // First kernel of the pass
    logic first_krnl;
    // Issue allowed this cycle
    logic can_issue;

    // Per-group hit, before priority
    logic g1_hit;
    logic g2_hit;
    logic g3_hit;
    logic g4_hit;
    logic g5_hit;
    logic g6_hit;
    logic g7_hit;
    logic g8_hit;
    logic g9_hit;
    logic g10_hit;

    // Next values of the issue registers
    logic pipe_d;
    logic pm_d;
    logic rm0_d;
    logic rm1_d;
    logic start0_d;
    logic start1_d;
    logic start2_d;
    logic wren1_d;
    logic wren2_d;
    // Next values of the depthwise-conv tags
    logic rm_conv_d;
    logic pv_d;

    //////////////////////////////////////////////////
    // Qualifiers
    //////////////////////////////////////////////////

    assign state_ok   = (state == st_active) || (state == st_wait_last_write);
    assign conv_rdy   = !conv_map_empty;
    assign part_rdy   = !part_map_empty;
    assign resd_rdy   = !resd_map_empty;
    assign prev_rdy   = !prev_map_empty;
    assign first_krnl = (krnl_count == '0);
    // Hold off while the last issue is still at the output
    assign can_issue  = state_ok && !pipe_busy;

    // Opcode bits and required FIFOs, one line per group
    assign g1_hit  = (opcode_cfg[op_0] || opcode_cfg[op_4])
                     && conv_rdy && part_rdy && resd_rdy;
    assign g2_hit  = (opcode_cfg[op_1] || opcode_cfg[op_11])
                     && conv_rdy && part_rdy && prev_rdy;
    assign g3_hit  = (opcode_cfg[op_2] || opcode_cfg[op_6] || opcode_cfg[op_14])
                     && conv_rdy;
    assign g4_hit  = (opcode_cfg[op_3] || opcode_cfg[op_13])
                     && conv_rdy && prev_rdy;
    assign g5_hit  = opcode_cfg[op_5]
                     && conv_rdy && part_rdy && resd_rdy && prev_rdy;
    assign g6_hit  = opcode_cfg[op_7] && conv_rdy && resd_rdy && prev_rdy;
    assign g7_hit  = opcode_cfg[op_8] && conv_rdy && part_rdy && resd_rdy;
    assign g8_hit  = (opcode_cfg[op_9] || opcode_cfg[op_17]) && conv_rdy && resd_rdy;
    assign g9_hit  = opcode_cfg[op_10] && conv_rdy && part_rdy;
    assign g10_hit = opcode_cfg[op_15] && conv_rdy && part_rdy;

    //////////////////////////////////////////////////
    // Priority decode
    //////////////////////////////////////////////////

    always_comb begin
        pipe_d   = 1'b0;
        pm_d     = 1'b0;
        rm0_d    = 1'b0;
        rm1_d    = 1'b0;
        start0_d = 1'b0;
        start1_d = 1'b0;
        start2_d = 1'b0;
        wren1_d  = 1'b0;
        wren2_d  = 1'b0;
        if (can_issue) begin
            // First hit in group order wins
            if (g1_hit || g2_hit) begin
                pipe_d   = 1'b1;
                start1_d = 1'b1;
                pm_d     = first_krnl;
            end else if (g3_hit || g4_hit) begin
                pipe_d   = 1'b1;
                start0_d = 1'b1;
            end else if (g5_hit) begin
                pipe_d   = 1'b1;
                start2_d = 1'b1;
                pm_d     = first_krnl;
                rm1_d    = first_krnl;
            end else if (g6_hit) begin
                pipe_d   = 1'b1;
                start1_d = 1'b1;
                rm0_d    = first_krnl;
            end else if (g7_hit) begin
                // Add only, no conv start
                pipe_d  = 1'b1;
                pm_d    = 1'b1;
                rm1_d   = 1'b1;
                wren2_d = 1'b1;
            end else if (g8_hit) begin
                pipe_d  = 1'b1;
                rm0_d   = 1'b1;
                wren1_d = 1'b1;
            end else if (g9_hit) begin
                pipe_d   = 1'b1;
                pm_d     = 1'b1;
                start1_d = 1'b1;
            end else if (g10_hit) begin
                pipe_d  = 1'b1;
                pm_d    = 1'b1;
                wren1_d = 1'b1;
            end
        end
    end

    // Depthwise-conv read tags, state and flags not involved
    assign rm_conv_d = dwc_fifo_rden && (opcode_cfg[op_0] || opcode_cfg[op_2]);
    assign pv_d      = dwc_fifo_rden && (opcode_cfg[op_1] || opcode_cfg[op_3]
                                         || opcode_cfg[op_5] || opcode_cfg[op_7]);

    //////////////////////////////////////////////////
    // Registers
    //////////////////////////////////////////////////

    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            issue_pipe         <= 1'b0;
            issue_pm           <= 1'b0;
            issue_rm0          <= 1'b0;
            issue_rm1          <= 1'b0;
            conv1x1_pip_start0 <= 1'b0;
            conv1x1_pip_start1 <= 1'b0;
            conv1x1_pip_start2 <= 1'b0;
            outbuf_fifo_wren1  <= 1'b0;
            outbuf_fifo_wren2  <= 1'b0;
        end else if (fas_rdy_n) begin
            // Downstream not ready
            issue_pipe         <= 1'b0;
            issue_pm           <= 1'b0;
            issue_rm0          <= 1'b0;
            issue_rm1          <= 1'b0;
            conv1x1_pip_start0 <= 1'b0;
            conv1x1_pip_start1 <= 1'b0;
            conv1x1_pip_start2 <= 1'b0;
            outbuf_fifo_wren1  <= 1'b0;
            outbuf_fifo_wren2  <= 1'b0;
        end else begin
            issue_pipe         <= pipe_d;
            issue_pm           <= pm_d;
            issue_rm0          <= rm0_d;
            issue_rm1          <= rm1_d;
            conv1x1_pip_start0 <= start0_d;
            conv1x1_pip_start1 <= start1_d;
            conv1x1_pip_start2 <= start2_d;
            outbuf_fifo_wren1  <= wren1_d;
            outbuf_fifo_wren2  <= wren2_d;
        end
    end

    // Tag registers
    always_ff @(posedge clk_FAS or negedge rst_n) begin
        if (!rst_n) begin
            issue_rm_conv <= 1'b0;
            issue_pv      <= 1'b0;
        end else if (fas_rdy_n) begin
            issue_rm_conv <= 1'b0;
            issue_pv      <= 1'b0;
        end else begin
            issue_rm_conv <= rm_conv_d;
            issue_pv      <= pv_d;
        end
    end

endmodule

//--- fas_pip_ctrl.sv
module fas_pip_ctrl #(
    parameter int fifo_latency    = pipe_timing_pkg::fas_fifo_latency_default,
    parameter int vec_add_latency = pipe_timing_pkg::vec_add_latency_default
) (
    input  logic                       clk_FAS,
    input  logic                       rst_n,
    input  logic                       fas_rdy_n,
    input  layer_cfg_pkg::opcode_cfg_t  opcode_cfg,
    input  layer_cfg_pkg::layer_state_t state,
    input  logic                       conv_map_empty,
    input  logic                       part_map_empty,
    input  logic                       resd_map_empty,
    input  logic                       prev_map_empty,
    input  layer_cfg_pkg::krnl_count_t  krnl_count,
    input  logic                       dwc_fifo_rden,
    output logic                       pipe_enable,
    output logic                       conv1x1_pip_start0,
    output logic                       conv1x1_pip_start1,
    output logic                       conv1x1_pip_start2,
    output logic                       vector_add_pm,
    output logic                       vector_add_rm0,
    output logic                       vector_add_rm1,
    output logic                       vector_add_rm_conv,
    output logic                       vector_add_pv,
    output logic                       outbuf_fifo_wren1,
    output logic                       outbuf_fifo_wren2
);

    // Residual-1 waits for two map reads and the adder
    localparam int rm1_depth = 2 * fifo_latency + vec_add_latency;

    // Registered strobes ahead of the delay lines
    logic issue_pipe;
    logic issue_pm;
    logic issue_rm0;
    logic issue_rm1;
    logic issue_rm_conv;
    logic issue_pv;

    //////////////////////////////////////////////////
    // Issue decode
    //////////////////////////////////////////////////

    pip_issue i_pip_issue (
        .clk_FAS            (clk_FAS),
        .rst_n              (rst_n),
        .fas_rdy_n          (fas_rdy_n),
        .opcode_cfg         (opcode_cfg),
        .state              (state),
        .conv_map_empty     (conv_map_empty),
        .part_map_empty     (part_map_empty),
        .resd_map_empty     (resd_map_empty),
        .prev_map_empty     (prev_map_empty),
        .krnl_count         (krnl_count),
        .dwc_fifo_rden      (dwc_fifo_rden),
        // Throttle from the delayed enable
        .pipe_busy          (pipe_enable),
        .issue_pipe         (issue_pipe),
        .issue_pm           (issue_pm),
        .issue_rm0          (issue_rm0),
        .issue_rm1          (issue_rm1),
        .issue_rm_conv      (issue_rm_conv),
        .issue_pv           (issue_pv),
        .conv1x1_pip_start0 (conv1x1_pip_start0),
        .conv1x1_pip_start1 (conv1x1_pip_start1),
        .conv1x1_pip_start2 (conv1x1_pip_start2),
        .outbuf_fifo_wren1  (outbuf_fifo_wren1),
        .outbuf_fifo_wren2  (outbuf_fifo_wren2)
    );

    //////////////////////////////////////////////////
    // Delay lines
    //////////////////////////////////////////////////

    // Map FIFO read latency
    pip_delay_line #(.depth(fifo_latency)) i_dly_pipe (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .din (issue_pipe), .dout (pipe_enable)
    );
    pip_delay_line #(.depth(fifo_latency)) i_dly_pm (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .din (issue_pm), .dout (vector_add_pm)
    );
    pip_delay_line #(.depth(fifo_latency)) i_dly_rm0 (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .din (issue_rm0), .dout (vector_add_rm0)
    );
    pip_delay_line #(.depth(fifo_latency)) i_dly_rm_conv (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .din (issue_rm_conv),
        .dout (vector_add_rm_conv)
    );
    pip_delay_line #(.depth(fifo_latency)) i_dly_pv (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .din (issue_pv), .dout (vector_add_pv)
    );

    // Residual-1 path
    pip_delay_line #(.depth(rm1_depth)) i_dly_rm1 (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .din (issue_rm1), .dout (vector_add_rm1)
    );

endmodule

//--- tb_pip_checker.sv
module tb_pip_checker (
    input  logic                        clk_FAS,
    input  logic                        rst_n,
    input  logic                        fas_rdy_n,
    input  layer_cfg_pkg::opcode_cfg_t  opcode_cfg,
    input  layer_cfg_pkg::layer_state_t state,
    input  logic                        conv_map_empty,
    input  logic                        part_map_empty,
    input  logic                        resd_map_empty,
    input  logic                        prev_map_empty,
    input  layer_cfg_pkg::krnl_count_t  krnl_count,
    input  logic                        dwc_fifo_rden,
    input  logic [10:0]                 dut_out,
    output int                          error_count
);
    timeunit 1ns;
    timeprecision 1ns;

    import layer_cfg_pkg::*;
    import pipe_timing_pkg::*;

    // Delay of each output behind the issue register
    localparam int fifo_lat = fas_fifo_latency_default;
    localparam int rm1_lat  = resd1_delay_default;

    // Bit order of the strobe vector
    localparam int b_pipe    = 0;
    localparam int b_pm      = 1;
    localparam int b_rm0     = 2;
    localparam int b_rm1     = 3;
    localparam int b_rm_conv = 4;
    localparam int b_pv      = 5;
    localparam int b_start0  = 6;
    localparam int b_start1  = 7;
    localparam int b_start2  = 8;
    localparam int b_wren1   = 9;
    localparam int b_wren2   = 10;

    // Depthwise-conv reads tagged as residual add
    localparam opcode_cfg_t rm_conv_ops = (opcode_cfg_t'(1) << op_0)
                                          | (opcode_cfg_t'(1) << op_2);
    // Depthwise-conv reads tagged as previous-map add
    localparam opcode_cfg_t pv_ops = (opcode_cfg_t'(1) << op_1)
                                     | (opcode_cfg_t'(1) << op_3)
                                     | (opcode_cfg_t'(1) << op_5)
                                     | (opcode_cfg_t'(1) << op_7);

    // Issue register contents, k cycles back in entry k
    logic [10:0] hist [0:rm1_lat];

    //////////////////////////////////////////////////
    // Control rules
    //////////////////////////////////////////////////

    function automatic opcode_cfg_t group_ops(int g);
        case (g)
            1:  return opcode_cfg_t'(1) << op_0 | opcode_cfg_t'(1) << op_4;
            2:  return opcode_cfg_t'(1) << op_1 | opcode_cfg_t'(1) << op_11;
            3:  return opcode_cfg_t'(1) << op_2 | opcode_cfg_t'(1) << op_6
                       | opcode_cfg_t'(1) << op_14;
            4:  return opcode_cfg_t'(1) << op_3 | opcode_cfg_t'(1) << op_13;
            5:  return opcode_cfg_t'(1) << op_5;
            6:  return opcode_cfg_t'(1) << op_7;
            7:  return opcode_cfg_t'(1) << op_8;
            8:  return opcode_cfg_t'(1) << op_9 | opcode_cfg_t'(1) << op_17;
            9:  return opcode_cfg_t'(1) << op_10;
            10: return opcode_cfg_t'(1) << op_15;
            default: return '0;
        endcase
    endfunction

    // Required FIFOs as conv, part, resd, prev
    function automatic logic [3:0] group_needs(int g);
        case (g)
            1, 7:  return 4'b1110;
            2:     return 4'b1101;
            3:     return 4'b1000;
            4:     return 4'b1001;
            5:     return 4'b1111;
            6:     return 4'b1011;
            8:     return 4'b1010;
            default: return 4'b1100;
        endcase
    endfunction

    function automatic logic [10:0] group_strobes(int g, logic first);
        logic [10:0] v;
        v = '0;
        v[b_pipe] = (g != 0);
        case (g)
            1, 2: begin
                v[b_start1] = 1'b1;
                v[b_pm]     = first;
            end
            3, 4: v[b_start0] = 1'b1;
            5: begin
                v[b_start2] = 1'b1;
                v[b_pm]     = first;
                v[b_rm1]    = first;
            end
            6: begin
                v[b_start1] = 1'b1;
                v[b_rm0]    = first;
            end
            7: begin
                v[b_pm]    = 1'b1;
                v[b_rm1]   = 1'b1;
                v[b_wren2] = 1'b1;
            end
            8: begin
                v[b_rm0]   = 1'b1;
                v[b_wren1] = 1'b1;
            end
            9: begin
                v[b_pm]     = 1'b1;
                v[b_start1] = 1'b1;
            end
            10: begin
                v[b_pm]    = 1'b1;
                v[b_wren1] = 1'b1;
            end
            default: v = '0;
        endcase
        return v;
    endfunction

    // Next issue register value from the inputs seen at this edge
    function automatic logic [10:0] next_issue();
        logic [3:0]  empties;
        logic [10:0] v;
        int          win;
        empties = {conv_map_empty, part_map_empty, resd_map_empty, prev_map_empty};
        win = 0;
        // Throttle is the modelled pipe_enable as it stands before this edge
        if ((state == st_active || state == st_wait_last_write) && !hist[fifo_lat][b_pipe]) begin
            for (int g = 1; g <= 10; g++) begin
                if (win == 0 && (opcode_cfg & group_ops(g)) != '0
                    && (empties & group_needs(g)) == 4'b0000) begin
                    win = g;
                end
            end
        end
        v = group_strobes(win, krnl_count == '0);
        // Depthwise-conv read tags
        v[b_rm_conv] = dwc_fifo_rden && ((opcode_cfg & rm_conv_ops) != '0);
        v[b_pv]      = dwc_fifo_rden && ((opcode_cfg & pv_ops) != '0);
        return v;
    endfunction

    //////////////////////////////////////////////////
    // Comparison
    //////////////////////////////////////////////////

    function automatic string bit_name(int b);
        case (b)
            b_pipe:    return "pipe_enable";
            b_pm:      return "vector_add_pm";
            b_rm0:     return "vector_add_rm0";
            b_rm1:     return "vector_add_rm1";
            b_rm_conv: return "vector_add_rm_conv";
            b_pv:      return "vector_add_pv";
            b_start0:  return "conv1x1_pip_start0";
            b_start1:  return "conv1x1_pip_start1";
            b_start2:  return "conv1x1_pip_start2";
            b_wren1:   return "outbuf_fifo_wren1";
            default:   return "outbuf_fifo_wren2";
        endcase
    endfunction

    initial error_count = 0;

    always @(posedge clk_FAS or negedge rst_n) begin : model
        logic [10:0] expect_out;
        logic [10:0] issue_next;
        if (!rst_n) begin
            for (int k = 0; k <= rm1_lat; k++) begin
                hist[k] = '0;
            end
        end else begin
            // Undelayed strobes first, then the delayed ones
            expect_out = hist[0];
            expect_out[b_pipe]    = hist[fifo_lat][b_pipe];
            expect_out[b_pm]      = hist[fifo_lat][b_pm];
            expect_out[b_rm0]     = hist[fifo_lat][b_rm0];
            expect_out[b_rm_conv] = hist[fifo_lat][b_rm_conv];
            expect_out[b_pv]      = hist[fifo_lat][b_pv];
            expect_out[b_rm1]     = hist[rm1_lat][b_rm1];
            for (int b = 0; b < 11; b++) begin
                if (dut_out[b] !== expect_out[b]) begin
                    $display("CHECK FAILED at %0t ns: %s expected %0b, actual %0b",
                             $time, bit_name(b), expect_out[b], dut_out[b]);
                    error_count++;
                end
            end
            // Decide before the history moves on
            issue_next = next_issue();
            for (int k = rm1_lat; k > 0; k--) begin
                hist[k] = hist[k-1];
            end
            // Not ready downstream blocks new strobes
            hist[0] = fas_rdy_n ? 11'b0 : issue_next;
        end
    end

endmodule

//--- tb_fas_pip_ctrl.sv
module tb_fas_pip_ctrl;
    timeunit 1ns;
    timeprecision 1ns;

    import layer_cfg_pkg::*;

    localparam int clk_period = 100;

    logic         clk_FAS;
    logic         rst_n;
    logic         fas_rdy_n;
    opcode_cfg_t  opcode_cfg;
    layer_state_t state;
    logic         conv_map_empty;
    logic         part_map_empty;
    logic         resd_map_empty;
    logic         prev_map_empty;
    krnl_count_t  krnl_count;
    logic         dwc_fifo_rden;
    // DUT outputs, same bit order as the checker
    wire  [10:0]  dut_out;

    int           error_count;
    int           setup_errors;
    logic [31:0]  rng_state;
    longint       watchdog_ns;
    bit           vectors_loaded;

    // Stimulus rows
    int           q_op [$];
    layer_state_t q_state [$];
    bit           q_rand [$];
    logic [3:0]   q_empty [$];
    int           q_krnl [$];
    bit           q_rden [$];
    bit           q_rdy_n [$];
    int           q_hold [$];

    fas_pip_ctrl i_fas_pip_ctrl (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .fas_rdy_n (fas_rdy_n),
        .opcode_cfg (opcode_cfg), .state (state),
        .conv_map_empty (conv_map_empty), .part_map_empty (part_map_empty),
        .resd_map_empty (resd_map_empty), .prev_map_empty (prev_map_empty),
        .krnl_count (krnl_count), .dwc_fifo_rden (dwc_fifo_rden),
        .pipe_enable (dut_out[0]), .vector_add_pm (dut_out[1]),
        .vector_add_rm0 (dut_out[2]), .vector_add_rm1 (dut_out[3]),
        .vector_add_rm_conv (dut_out[4]), .vector_add_pv (dut_out[5]),
        .conv1x1_pip_start0 (dut_out[6]), .conv1x1_pip_start1 (dut_out[7]),
        .conv1x1_pip_start2 (dut_out[8]), .outbuf_fifo_wren1 (dut_out[9]),
        .outbuf_fifo_wren2 (dut_out[10])
    );

    tb_pip_checker i_pip_checker (
        .clk_FAS (clk_FAS), .rst_n (rst_n), .fas_rdy_n (fas_rdy_n),
        .opcode_cfg (opcode_cfg), .state (state),
        .conv_map_empty (conv_map_empty), .part_map_empty (part_map_empty),
        .resd_map_empty (resd_map_empty), .prev_map_empty (prev_map_empty),
        .krnl_count (krnl_count), .dwc_fifo_rden (dwc_fifo_rden),
        .dut_out (dut_out), .error_count (error_count)
    );

    initial begin
        clk_FAS = 1'b0;
        forever #(clk_period / 2) clk_FAS = ~clk_FAS;
    end

    function automatic logic [31:0] xorshift32(logic [31:0] s);
        s ^= s << 13;
        s ^= s >> 17;
        s ^= s << 5;
        return s;
    endfunction

    function automatic layer_state_t state_from_code(string code);
        case (code)
            "krn":  return st_ld_1x1_krn;
            "krb":  return st_ld_1x1_krb;
            "cfg":  return st_cfg_awp;
            "sawp": return st_start_awp;
            "act":  return st_active;
            "wlw":  return st_wait_last_write;
            "cmpl": return st_send_complete;
            default: return st_idle;
        endcase
    endfunction

    //////////////////////////////////////////////////
    // Stimulus file
    //////////////////////////////////////////////////

    task automatic load_vectors();
        int         fd;
        int         rc;
        int         op_idx;
        int         kc;
        int         rd;
        int         rn;
        int         hold;
        logic [3:0] flags;
        string      tok;
        string      st_code;
        string      emp;
        string      rest;
        fd = $fopen("pip_input_vectors.txt", "r");
        if (fd == 0) begin
            $display("Could not open pip_input_vectors.txt");
            setup_errors++;
            return;
        end
        while (!$feof(fd)) begin
            rc = $fscanf(fd, "%s", tok);
            if (rc != 1) break;
            // Comment line
            if (tok.substr(0, 0) == "#") begin
                rc = $fgets(rest, fd);
                continue;
            end
            rc = $sscanf(tok, "%d", op_idx);
            rc = $fscanf(fd, "%s %s %d %d %d %d", st_code, emp, kc, rd, rn, hold);
            if (rc != 6) begin
                $display("Stimulus row starting with %s is incomplete", tok);
                setup_errors++;
                break;
            end
            if (state_from_code(st_code) == st_idle && st_code != "idle") begin
                $display("Unknown state code %s in stimulus file", st_code);
                setup_errors++;
            end
            flags = 4'b1111;
            if (emp != "r") rc = $sscanf(emp, "%b", flags);
            q_op.push_back(op_idx);
            q_state.push_back(state_from_code(st_code));
            q_rand.push_back(emp == "r");
            q_empty.push_back(flags);
            q_krnl.push_back(kc);
            q_rden.push_back(rd != 0);
            q_rdy_n.push_back(rn != 0);
            q_hold.push_back(hold);
        end
        $fclose(fd);
        if (q_op.size() == 0) begin
            $display("No stimulus rows were read");
            setup_errors++;
        end
    endtask

    // One row, held for its cycle count, changed on falling edges
    task automatic drive_row(int i);
        logic [3:0] flags;
        repeat (q_hold[i]) begin
            flags = q_empty[i];
            if (q_rand[i]) begin
                rng_state = xorshift32(rng_state);
                // About one flag in four empty
                flags = rng_state[3:0] & rng_state[7:4];
            end
            opcode_cfg = '0;
            if (q_op[i] < 18) opcode_cfg[q_op[i]] = 1'b1;
            state = q_state[i];
            {conv_map_empty, part_map_empty, resd_map_empty, prev_map_empty} = flags;
            krnl_count    = krnl_count_t'(q_krnl[i]);
            dwc_fifo_rden = q_rden[i];
            fas_rdy_n     = q_rdy_n[i];
            @(negedge clk_FAS);
        end
    endtask

    //////////////////////////////////////////////////
    // Sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst_n          = 1'b0;
        fas_rdy_n      = 1'b1;
        opcode_cfg     = '0;
        state          = st_idle;
        conv_map_empty = 1'b1;
        part_map_empty = 1'b1;
        resd_map_empty = 1'b1;
        prev_map_empty = 1'b1;
        krnl_count     = '0;
        dwc_fifo_rden  = 1'b0;
        setup_errors   = 0;
        rng_state      = 32'ha87b82b1;
        load_vectors();
        watchdog_ns = 50;
        foreach (q_hold[i]) watchdog_ns += q_hold[i];
        watchdog_ns = watchdog_ns * clk_period;
        vectors_loaded = 1'b1;
        repeat (8) @(negedge clk_FAS);
        rst_n = 1'b1;
        foreach (q_op[i]) drive_row(i);
        // Back to idle and let the delay lines drain
        state         = st_idle;
        opcode_cfg    = '0;
        dwc_fifo_rden = 1'b0;
        repeat (12) @(negedge clk_FAS);
        $display("Errors: %0d value mismatches, %0d other", error_count, setup_errors);
        if (error_count == 0 && setup_errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    initial begin
        wait (vectors_loaded);
        #(watchdog_ns);
        $display("Run timed out after %0d ns without finishing", watchdog_ns);
        $display("Regression failed");
        $finish;
    end

endmodule

//--- pip_input_vectors.txt
# op state empty(conv part resd prev, or r for random) krnl rden rdy_n hold
# states idle krn krb cfg sawp act wlw cmpl, op 18 leaves the opcode word clear
18 idle 1111 0 0 0 3
0 idle 0000 0 0 0 4
5 krn 0000 0 0 0 3
8 cfg 0000 0 0 0 3
7 sawp 0000 0 0 0 3
1 cmpl 0000 0 0 0 3
0 act 0000 0 0 0 8
0 act 0000 5 0 0 6
4 wlw 0001 0 0 0 6
0 act 0010 0 0 0 4
11 act 0010 2 0 0 6
1 act 0000 0 0 0 6
2 act 0111 0 0 0 6
14 wlw 0000 0 0 0 4
3 act 0110 0 0 0 6
13 act 0001 0 0 0 4
5 act 0000 0 0 0 10
5 act 0000 9 0 0 6
5 act 0100 0 0 0 4
7 act 0000 0 0 0 6
7 act 0100 1 0 0 6
8 act 0001 0 0 0 10
9 act 0000 0 0 0 6
17 act 0010 0 0 0 4
10 wlw 0000 0 0 0 6
15 act 1000 0 0 0 4
15 act 0000 0 0 0 6
12 act 0000 0 0 0 8
16 act 0000 0 0 0 8
0 act 1111 0 1 0 3
2 act 1111 0 1 0 3
1 act 1111 0 1 0 3
3 act 1111 0 1 0 3
5 act 1111 0 1 0 3
7 act 1111 0 1 0 3
4 act 1111 0 1 0 3
5 act 0000 0 0 0 3
5 act 0000 0 1 1 6
5 act 0000 0 0 0 4
5 act r 0 0 0 20
0 act r 3 1 0 20
7 wlw r 0 0 0 20

//--- files.f
layer_cfg_pkg.sv
pipe_timing_pkg.sv
pip_delay_line.sv
pip_issue.sv
fas_pip_ctrl.sv
tb_pip_checker.sv
tb_fas_pip_ctrl.sv

//--- Bender.yml
package:
  name: fas_pip_ctrl

sources:
  - layer_cfg_pkg.sv
  - pipe_timing_pkg.sv
  - pip_delay_line.sv
  - pip_issue.sv
  - fas_pip_ctrl.sv
  - target: test
    files:
      - tb_pip_checker.sv
      - tb_fas_pip_ctrl.sv
